// ==== source/dllp_defs.svh ====
// DLLP receive path parameters
// stream widths, CRC-16 constants and error counter width

`ifndef DLLP_DEFS_SVH
`define DLLP_DEFS_SVH

// stream word, one full DLLP body per beat
`define DLLP_DATA_W 32

// tuser bit 0 marks a DLLP beat
`define DLLP_USER_W 4

// link CRC-16, no final inversion
`define DLLP_CRC_SEED 16'hFFFF
`define DLLP_CRC_POLY 16'h100B

// saturating bad-CRC count
`define DLLP_ERR_W 8

`endif

// ==== source/dllp_pkg.sv ====
// DLLP receive types
// word layout, type codes, flow-control enums and decoder states

`include "dllp_defs.svh"

package dllp_pkg;

  // [31:24] type, [21:14] HdrFC, [11:0] DataFC or sequence number
  typedef logic [`DLLP_DATA_W-1:0] dllp_word_t;
  typedef logic [7:0]              dllp_type_t;
  typedef logic [15:0]             crc16_t;
  typedef logic [11:0]             seq_num_t;
  typedef logic [7:0]              hdr_fc_t;
  typedef logic [11:0]             data_fc_t;

  localparam dllp_type_t DLLP_ACK         = 8'h00;
  localparam dllp_type_t DLLP_NAK         = 8'h10;
  // flow-control codes, only the upper nibble is decoded
  localparam dllp_type_t DLLP_INITFC1_P   = 8'h40;
  localparam dllp_type_t DLLP_INITFC1_NP  = 8'h50;
  localparam dllp_type_t DLLP_INITFC1_CPL = 8'h60;
  localparam dllp_type_t DLLP_INITFC2_P   = 8'hC0;
  localparam dllp_type_t DLLP_INITFC2_NP  = 8'hD0;
  localparam dllp_type_t DLLP_INITFC2_CPL = 8'hE0;
  localparam dllp_type_t DLLP_UPDATEFC_P  = 8'h80;
  localparam dllp_type_t DLLP_UPDATEFC_NP = 8'h90;
  localparam dllp_type_t DLLP_UPDATEFC_CPL = 8'hA0;

  typedef enum logic [1:0] {
    FC_P,
    FC_NP,
    FC_CPL
  } fc_class_e;

  typedef enum logic [1:0] {
    FC_INIT1,
    FC_INIT2,
    FC_UPDATE
  } fc_kind_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_CRC,
    ST_PROCESS
  } dec_state_e;

endpackage

// ==== source/dllp_skid_buffer.sv ====
// AXI-Stream register slice
// main plus skid register, registered ready at full throughput

`timescale 1ns/1ps
`include "dllp_defs.svh"

module dllp_skid_buffer (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  dllp_pkg::dllp_word_t     s_tdata_i,
  input  logic                     s_tvalid_i,
  input  logic                     s_tlast_i,
  input  logic [`DLLP_USER_W-1:0]  s_tuser_i,
  output logic                     s_tready_o,
  output dllp_pkg::dllp_word_t     m_tdata_o,
  output logic                     m_tvalid_o,
  output logic                     m_tlast_o,
  output logic [`DLLP_USER_W-1:0]  m_tuser_o,
  input  logic                     m_tready_i
);
  import dllp_pkg::*;

  dllp_word_t              main_data_r, skid_data_r;
  logic                    main_last_r, skid_last_r;
  logic [`DLLP_USER_W-1:0] main_user_r, skid_user_r;
  logic                    main_valid_r, skid_valid_r, ready_r;
  logic                    main_valid_nxt, skid_valid_nxt, ready_nxt;
  logic                    load_main_in, load_main_skid, load_skid;

  always_comb begin
    main_valid_nxt = main_valid_r;
    skid_valid_nxt = skid_valid_r;
    load_main_in   = 1'b0;
    load_main_skid = 1'b0;
    load_skid      = 1'b0;
    if (ready_r) begin
      // input goes straight to the output if it is free or draining
      if (m_tready_i || !main_valid_r) begin
        main_valid_nxt = s_tvalid_i;
        load_main_in   = 1'b1;
      end else begin
        skid_valid_nxt = s_tvalid_i;
        load_skid      = 1'b1;
      end
    end else if (m_tready_i) begin
      main_valid_nxt = skid_valid_r;
      skid_valid_nxt = 1'b0;
      load_main_skid = 1'b1;
    end
  end

  // accept next cycle only if the skid entry cannot overflow
  assign ready_nxt = m_tready_i || (!skid_valid_r && (!main_valid_r || !s_tvalid_i));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      main_valid_r <= 1'b0;
      skid_valid_r <= 1'b0;
      ready_r      <= 1'b0;
    end else begin
      main_valid_r <= main_valid_nxt;
      skid_valid_r <= skid_valid_nxt;
      ready_r      <= ready_nxt;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_main_in) begin
      {main_data_r, main_last_r, main_user_r} <= {s_tdata_i, s_tlast_i, s_tuser_i};
    end else if (load_main_skid) begin
      {main_data_r, main_last_r, main_user_r} <= {skid_data_r, skid_last_r, skid_user_r};
    end
    if (load_skid) begin
      {skid_data_r, skid_last_r, skid_user_r} <= {s_tdata_i, s_tlast_i, s_tuser_i};
    end
  end

  assign s_tready_o = ready_r;
  assign m_tdata_o  = main_data_r;
  assign m_tvalid_o = main_valid_r;
  assign m_tlast_o  = main_last_r;
  assign m_tuser_o  = main_user_r;

  // a stalled beat must not change until it is taken
  a_hold_stalled: assert property (@(posedge clk_i) disable iff (rst_i)
    m_tvalid_o && !m_tready_i |=> m_tvalid_o && $stable({m_tdata_o, m_tlast_o, m_tuser_o}));

endmodule

// ==== source/dllp_crc16.sv ====
// DLLP CRC-16
// one 32-bit body per call, MSB first, seed all ones, no final inversion

`timescale 1ns/1ps
`include "dllp_defs.svh"

module dllp_crc16 (
  input  dllp_pkg::dllp_word_t data_i,
  output dllp_pkg::crc16_t     crc_o
);
  import dllp_pkg::*;

  crc16_t crc;
  logic   feedback;

  always_comb begin
    crc      = `DLLP_CRC_SEED;
    feedback = 1'b0;
    for (int i = `DLLP_DATA_W - 1; i >= 0; i--) begin
      feedback = crc[15] ^ data_i[i];
      crc      = {crc[14:0], 1'b0};
      if (feedback) begin
        crc = crc ^ `DLLP_CRC_POLY;
      end
    end
  end

  assign crc_o = crc;

endmodule

// ==== source/dllp_decoder.sv ====
// DLLP decoder
// pairs body and CRC beats, checks the CRC and classifies the DLLP
// Ack/Nak give a sequence report, flow-control types a credit write

`timescale 1ns/1ps
`include "dllp_defs.svh"

module dllp_decoder (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    link_up_i,
  input  dllp_pkg::dllp_word_t    s_tdata_i,
  input  logic                    s_tvalid_i,
  input  logic [`DLLP_USER_W-1:0] s_tuser_i,
  output logic                    s_tready_o,
  input  dllp_pkg::crc16_t        crc_i,
  output dllp_pkg::seq_num_t      seq_num_o,
  output logic                    seq_vld_o,
  output logic                    seq_ack_o,
  output logic                    fc_wr_o,
  output dllp_pkg::fc_class_e     fc_class_o,
  output dllp_pkg::fc_kind_e      fc_kind_o,
  output dllp_pkg::hdr_fc_t       fc_hdr_o,
  output dllp_pkg::data_fc_t      fc_data_o,
  output logic [`DLLP_ERR_W-1:0]  crc_err_cnt_o
);
  import dllp_pkg::*;

  localparam int unsigned USER_DLLP_BIT = 0;

  dec_state_e             state_r, state_nxt;
  dllp_word_t             body_r;
  crc16_t                 crc_r;
  logic [`DLLP_ERR_W-1:0] err_cnt_r;
  logic                   dllp_beat, crc_match, in_process, is_fc, is_ack_nak;
  dllp_type_t             type_byte;
  logic [3:0]             type_hi;

  // no ready in ST_PROCESS, and none in ST_IDLE while the link is down
  assign s_tready_o = (state_r == ST_WAIT_CRC) || ((state_r == ST_IDLE) && link_up_i);
  assign dllp_beat  = s_tvalid_i && s_tready_o && s_tuser_i[USER_DLLP_BIT];
  assign crc_match  = (s_tdata_i[15:0] == crc_r);

  always_comb begin
    state_nxt = state_r;
    case (state_r)
      ST_IDLE:     if (dllp_beat) state_nxt = ST_WAIT_CRC;
      ST_WAIT_CRC: if (dllp_beat) state_nxt = crc_match ? ST_PROCESS : ST_IDLE;
      default:     state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r   <= ST_IDLE;
      err_cnt_r <= '0;
    end else begin
      state_r <= state_nxt;
      if (state_r == ST_WAIT_CRC && dllp_beat && !crc_match && err_cnt_r != '1) begin
        err_cnt_r <= err_cnt_r + 1'b1;
      end
    end
  end

  // body and its CRC are captured together on the first beat
  always_ff @(posedge clk_i) begin
    if (state_r == ST_IDLE && dllp_beat) begin
      body_r <= s_tdata_i;
      crc_r  <= crc_i;
    end
  end

  assign type_byte  = body_r[31:24];
  assign type_hi    = type_byte[7:4];
  assign in_process = (state_r == ST_PROCESS);
  assign is_ack_nak = (type_byte == DLLP_ACK) || (type_byte == DLLP_NAK);

  always_comb begin
    is_fc     = 1'b1;
    fc_kind_o = FC_UPDATE;
    case (type_hi)
      DLLP_INITFC1_P[7:4], DLLP_INITFC1_NP[7:4], DLLP_INITFC1_CPL[7:4]: fc_kind_o = FC_INIT1;
      DLLP_INITFC2_P[7:4], DLLP_INITFC2_NP[7:4], DLLP_INITFC2_CPL[7:4]: fc_kind_o = FC_INIT2;
      DLLP_UPDATEFC_P[7:4], DLLP_UPDATEFC_NP[7:4], DLLP_UPDATEFC_CPL[7:4]: fc_kind_o = FC_UPDATE;
      // PM, vendor and anything else
      default: is_fc = 1'b0;
    endcase
  end

  always_comb begin
    fc_class_o = FC_P;
    case (type_hi)
      DLLP_INITFC1_NP[7:4], DLLP_INITFC2_NP[7:4], DLLP_UPDATEFC_NP[7:4]:    fc_class_o = FC_NP;
      DLLP_INITFC1_CPL[7:4], DLLP_INITFC2_CPL[7:4], DLLP_UPDATEFC_CPL[7:4]: fc_class_o = FC_CPL;
      default: fc_class_o = FC_P;
    endcase
  end

  assign seq_vld_o     = in_process && is_ack_nak;
  assign seq_ack_o     = (type_byte == DLLP_ACK);
  assign seq_num_o     = body_r[11:0];
  assign fc_wr_o       = in_process && is_fc;
  assign fc_hdr_o      = body_r[21:14];
  assign fc_data_o     = body_r[11:0];
  assign crc_err_cnt_o = err_cnt_r;

  a_one_event: assert property (@(posedge clk_i) disable iff (rst_i)
    !(seq_vld_o && fc_wr_o));

  // events only follow an accepted CRC beat that matched
  a_event_after_crc: assert property (@(posedge clk_i) disable iff (rst_i)
    (seq_vld_o || fc_wr_o) |-> $past(state_r == ST_WAIT_CRC && dllp_beat && crc_match));

endmodule

// ==== source/fc_credit_store.sv ====
// transmit flow-control credit store
// header and data credits per class, InitFC1/InitFC2 completion flags

`timescale 1ns/1ps

module fc_credit_store (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                fc_wr_i,
  input  dllp_pkg::fc_class_e fc_class_i,
  input  dllp_pkg::fc_kind_e  fc_kind_i,
  input  dllp_pkg::hdr_fc_t   fc_hdr_i,
  input  dllp_pkg::data_fc_t  fc_data_i,
  output dllp_pkg::hdr_fc_t   tx_fc_ph_o,
  output dllp_pkg::data_fc_t  tx_fc_pd_o,
  output dllp_pkg::hdr_fc_t   tx_fc_nph_o,
  output dllp_pkg::data_fc_t  tx_fc_npd_o,
  output dllp_pkg::hdr_fc_t   tx_fc_cplh_o,
  output dllp_pkg::data_fc_t  tx_fc_cpld_o,
  output logic                fc1_done_o,
  output logic                fc2_done_o
);
  import dllp_pkg::*;

  // indexed by class
  hdr_fc_t    hdr_r  [3];
  data_fc_t   data_r [3];
  logic [2:0] init1_seen_r;
  logic [2:0] init2_seen_r;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      hdr_r        <= '{default: '0};
      data_r       <= '{default: '0};
      init1_seen_r <= '0;
      init2_seen_r <= '0;
    end else if (fc_wr_i) begin
      // init and update writes all replace the class credits
      hdr_r[fc_class_i]  <= fc_hdr_i;
      data_r[fc_class_i] <= fc_data_i;
      if (fc_kind_i == FC_INIT1) begin
        init1_seen_r[fc_class_i] <= 1'b1;
      end
      if (fc_kind_i == FC_INIT2) begin
        init2_seen_r[fc_class_i] <= 1'b1;
      end
    end
  end

  assign tx_fc_ph_o   = hdr_r[FC_P];
  assign tx_fc_pd_o   = data_r[FC_P];
  assign tx_fc_nph_o  = hdr_r[FC_NP];
  assign tx_fc_npd_o  = data_r[FC_NP];
  assign tx_fc_cplh_o = hdr_r[FC_CPL];
  assign tx_fc_cpld_o = data_r[FC_CPL];
  assign fc1_done_o   = &init1_seen_r;
  assign fc2_done_o   = &init2_seen_r;

endmodule

// ==== source/dllp_rx_top.sv ====
// DLLP receive top level
// skid buffer, CRC check and decoder feeding the flow-control credit store

`timescale 1ns/1ps
`include "dllp_defs.svh"

module dllp_rx_top (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    link_up_i,
  input  dllp_pkg::dllp_word_t    s_axis_tdata_i,
  input  logic                    s_axis_tvalid_i,
  input  logic                    s_axis_tlast_i,
  input  logic [`DLLP_USER_W-1:0] s_axis_tuser_i,
  output logic                    s_axis_tready_o,
  output dllp_pkg::seq_num_t      seq_num_o,
  output logic                    seq_vld_o,
  output logic                    seq_ack_o,
  output dllp_pkg::hdr_fc_t       tx_fc_ph_o,
  output dllp_pkg::data_fc_t      tx_fc_pd_o,
  output dllp_pkg::hdr_fc_t       tx_fc_nph_o,
  output dllp_pkg::data_fc_t      tx_fc_npd_o,
  output dllp_pkg::hdr_fc_t       tx_fc_cplh_o,
  output dllp_pkg::data_fc_t      tx_fc_cpld_o,
  output logic                    fc1_done_o,
  output logic                    fc2_done_o,
  output logic [`DLLP_ERR_W-1:0]  crc_err_cnt_o
);
  import dllp_pkg::*;

  dllp_word_t              rd_tdata;
  logic                    rd_tvalid, rd_tready;
  logic [`DLLP_USER_W-1:0] rd_tuser;
  crc16_t                  crc;
  logic                    fc_wr;
  fc_class_e               fc_class;
  fc_kind_e                fc_kind;
  hdr_fc_t                 fc_hdr;
  data_fc_t                fc_data;

  // tlast is not needed downstream, the decoder state tells body from CRC
  dllp_skid_buffer dllp_skid_buffer_inst (
    .clk_i(clk_i), .rst_i(rst_i),
    .s_tdata_i(s_axis_tdata_i), .s_tvalid_i(s_axis_tvalid_i), .s_tlast_i(s_axis_tlast_i),
    .s_tuser_i(s_axis_tuser_i), .s_tready_o(s_axis_tready_o),
    .m_tdata_o(rd_tdata), .m_tvalid_o(rd_tvalid), .m_tlast_o(),
    .m_tuser_o(rd_tuser), .m_tready_i(rd_tready)
  );

  dllp_crc16 dllp_crc16_inst (.data_i(rd_tdata), .crc_o(crc));

  dllp_decoder dllp_decoder_inst (
    .clk_i(clk_i), .rst_i(rst_i), .link_up_i(link_up_i),
    .s_tdata_i(rd_tdata), .s_tvalid_i(rd_tvalid), .s_tuser_i(rd_tuser),
    .s_tready_o(rd_tready), .crc_i(crc),
    .seq_num_o(seq_num_o), .seq_vld_o(seq_vld_o), .seq_ack_o(seq_ack_o),
    .fc_wr_o(fc_wr), .fc_class_o(fc_class), .fc_kind_o(fc_kind),
    .fc_hdr_o(fc_hdr), .fc_data_o(fc_data), .crc_err_cnt_o(crc_err_cnt_o)
  );

  fc_credit_store fc_credit_store_inst (
    .clk_i(clk_i), .rst_i(rst_i),
    .fc_wr_i(fc_wr), .fc_class_i(fc_class), .fc_kind_i(fc_kind),
    .fc_hdr_i(fc_hdr), .fc_data_i(fc_data),
    .tx_fc_ph_o(tx_fc_ph_o), .tx_fc_pd_o(tx_fc_pd_o),
    .tx_fc_nph_o(tx_fc_nph_o), .tx_fc_npd_o(tx_fc_npd_o),
    .tx_fc_cplh_o(tx_fc_cplh_o), .tx_fc_cpld_o(tx_fc_cpld_o),
    .fc1_done_o(fc1_done_o), .fc2_done_o(fc2_done_o)
  );

endmodule

// ==== bench/dllp_rx_tasks.svh ====
// directed tests for the DLLP receive testbench
// stream driving, report and credit checks and one task per behavior

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
  checks++;
  if (exp !== act) begin
    errors++;
    $display("mismatch %s: expected %0h, actual %0h", name, exp, act);
  end
endtask

task automatic check_credits(input string name);
  check_value({name, " ph"}, exp_hdr[0], ph);
  check_value({name, " pd"}, exp_data[0], pd);
  check_value({name, " nph"}, exp_hdr[1], nph);
  check_value({name, " npd"}, exp_data[1], npd);
  check_value({name, " cplh"}, exp_hdr[2], cplh);
  check_value({name, " cpld"}, exp_data[2], cpld);
endtask

function automatic dllp_word_t ack_body(input logic ack, input seq_num_t seq);
  return {ack ? 8'h00 : 8'h10, 12'h000, seq};
endfunction

function automatic dllp_word_t fc_body(input dllp_type_t fc_type, input hdr_fc_t hdr,
                                       input data_fc_t data);
  return {fc_type, 2'b00, hdr, 2'b00, data};
endfunction

task automatic drive_beat(input dllp_word_t data, input logic dllp, input logic last);
  @(negedge clk);
  s_tdata    = data;
  s_tuser    = '0;
  s_tuser[0] = dllp;
  s_tlast    = last;
  s_tvalid   = 1'b1;
  // ready is registered, so what is seen here holds until the edge
  while (!s_tready) begin
    @(negedge clk);
  end
  @(posedge clk);
endtask

task automatic send_dllp(input dllp_word_t body, input crc16_t crc);
  drive_beat(body, 1'b1, 1'b0);
  drive_beat({16'h0000, crc}, 1'b1, 1'b1);
endtask

task automatic send_good(input dllp_word_t body);
  send_dllp(body, ref_crc(body));
endtask

task automatic release_bus();
  @(negedge clk);
  s_tvalid = 1'b0;
endtask

task automatic expect_report(input string name, input logic exp_ack, input seq_num_t exp_num);
  int          waited;
  logic [12:0] rep;
  waited = 0;
  while (report_q.size() == 0 && waited < WAIT_LIMIT) begin
    @(posedge clk);
    waited++;
  end
  if (report_q.size() == 0) begin
    errors++;
    $display("%s: no sequence report within %0d cycles", name, WAIT_LIMIT);
  end else begin
    rep = report_q.pop_front();
    check_value({name, " ack"}, exp_ack, rep[12]);
    check_value({name, " seq"}, exp_num, rep[11:0]);
  end
endtask

// an Ack sent behind earlier DLLPs whose report shows they were all handled
task automatic sync_marker(input string name);
  logic [31:0] r;
  r = next_rand();
  send_good(ack_body(1'b1, r[11:0]));
  release_bus();
  expect_report({name, " marker"}, 1'b1, r[11:0]);
endtask

// the low type nibble is random since only the upper one selects the class
task automatic send_fc(input dllp_type_t base, input int cls);
  logic [31:0] r;
  dllp_type_t  fc_type;
  r = next_rand();
  fc_type = {base[7:4] + 4'(cls), r[23:20]};
  exp_hdr[cls]  = r[7:0];
  exp_data[cls] = r[19:8];
  send_good(fc_body(fc_type, r[7:0], r[19:8]));
  release_bus();
endtask

task automatic test_ack_nak();
  logic [31:0] r;
  logic        ack;
  for (int i = 0; i < 6; i++) begin
    r = next_rand();
    // alternate so that both Ack and Nak are seen
    ack = (i % 2 == 0);
    send_good(ack_body(ack, r[11:0]));
    release_bus();
    expect_report("ack_nak", ack, r[11:0]);
  end
endtask

task automatic test_init_fc();
  for (int k = 0; k < 2; k++) begin
    for (int c = 0; c < 3; c++) begin
      send_fc((k == 0) ? 8'h40 : 8'hC0, c);
      sync_marker("init_fc");
      check_credits("init_fc");
      check_value("init_fc fc1_done", (k == 1) || (c == 2), fc1_done);
      check_value("init_fc fc2_done", (k == 1) && (c == 2), fc2_done);
    end
  end
endtask

task automatic test_update_fc();
  int cls;
  for (int i = 0; i < 5; i++) begin
    cls = next_rand() % 3;
    send_fc(8'h80, cls);
    sync_marker("update_fc");
    check_credits("update_fc");
    check_value("update_fc done", 2'b11, {fc1_done, fc2_done});
  end
endtask

task automatic test_bad_crc();
  logic [31:0]            r;
  logic [`DLLP_ERR_W-1:0] err_before;
  dllp_word_t             body;
  int                     waited;
  for (int i = 0; i < 2; i++) begin
    r = next_rand();
    err_before = crc_err_cnt;
    body = (i == 0) ? fc_body(8'h90, r[7:0], r[19:8]) : ack_body(1'b1, r[11:0]);
    // one flipped CRC bit
    send_dllp(body, ref_crc(body) ^ (16'h0001 << r[27:24]));
    release_bus();
    waited = 0;
    while (crc_err_cnt == err_before && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    check_value("bad_crc err_cnt", err_before + 1, crc_err_cnt);
    sync_marker("bad_crc");
    check_credits("bad_crc");
  end
endtask

task automatic test_filter_and_link();
  logic [31:0]            r;
  logic [`DLLP_ERR_W-1:0] err_before;
  err_before = crc_err_cnt;
  for (int i = 0; i < 3; i++) begin
    drive_beat(next_rand(), 1'b0, i == 2);
  end
  // PM_Enter_L1 followed by a vendor DLLP
  send_good(32'h2000_0000);
  r = next_rand();
  send_good({8'h30, r[23:0]});
  release_bus();
  sync_marker("filter_and_link");
  check_credits("filter_and_link");
  check_value("filter_and_link err_cnt", err_before, crc_err_cnt);

  @(negedge clk);
  link_up = 1'b0;
  r = next_rand();
  send_good(ack_body(1'b1, r[11:0]));
  release_bus();
  // the held Ack must stay in the skid buffer while the link is down
  repeat (20) @(posedge clk);
  check_value("filter_and_link held reports", 0, report_q.size());
  check_value("filter_and_link tready", 0, s_tready);
  @(negedge clk);
  link_up = 1'b1;
  expect_report("filter_and_link held", 1'b1, r[11:0]);
endtask

task automatic test_back_to_back();
  logic [31:0] r;
  logic [12:0] sent[$];
  logic [12:0] s;
  for (int i = 0; i < 6; i++) begin
    r = next_rand();
    sent.push_back({r[20], r[11:0]});
    send_good(ack_body(r[20], r[11:0]));
  end
  release_bus();
  while (sent.size() > 0) begin
    s = sent.pop_front();
    expect_report("back_to_back", s[12], s[11:0]);
  end
endtask

// ==== bench/dllp_rx_tb.sv ====
// DLLP receive testbench
// directed Ack/Nak, flow-control, bad-CRC and link tests on dllp_rx_top

`timescale 1ns/1ps
`include "dllp_defs.svh"

module dllp_rx_tb;
  import dllp_pkg::*;

  localparam int NUM_TESTS  = 6;
  localparam int WAIT_LIMIT = 40;

  logic                    clk, rst, link_up;
  dllp_word_t              s_tdata;
  logic                    s_tvalid, s_tlast, s_tready;
  logic [`DLLP_USER_W-1:0] s_tuser;
  seq_num_t                seq_num;
  logic                    seq_vld, seq_ack;
  hdr_fc_t                 ph, nph, cplh;
  data_fc_t                pd, npd, cpld;
  logic                    fc1_done, fc2_done;
  logic [`DLLP_ERR_W-1:0]  crc_err_cnt;

  int          errors = 0;
  int          checks = 0;
  logic [31:0] lcg_state = 32'hb98d;
  // {ack, sequence number} per report pulse
  logic [12:0] report_q[$];
  // expected credits, indexed P, NP, Cpl
  hdr_fc_t     exp_hdr[3];
  data_fc_t    exp_data[3];

  dllp_rx_top dllp_rx_top_inst (
    .clk_i(clk), .rst_i(rst), .link_up_i(link_up),
    .s_axis_tdata_i(s_tdata), .s_axis_tvalid_i(s_tvalid), .s_axis_tlast_i(s_tlast),
    .s_axis_tuser_i(s_tuser), .s_axis_tready_o(s_tready),
    .seq_num_o(seq_num), .seq_vld_o(seq_vld), .seq_ack_o(seq_ack),
    .tx_fc_ph_o(ph), .tx_fc_pd_o(pd), .tx_fc_nph_o(nph), .tx_fc_npd_o(npd),
    .tx_fc_cplh_o(cplh), .tx_fc_cpld_o(cpld),
    .fc1_done_o(fc1_done), .fc2_done_o(fc2_done), .crc_err_cnt_o(crc_err_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // collect report pulses mid-cycle, tasks read the queue on the rising edge
  always @(negedge clk) begin
    if (!rst && seq_vld) begin
      report_q.push_back({seq_ack, seq_num});
    end
  end

  initial begin
    #(NUM_TESTS * 2000);
    $display("watchdog expired after %0d ns, the tests did not finish", NUM_TESTS * 2000);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("Test failed");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // link CRC over one body, bit 31 first
  function automatic crc16_t ref_crc(input dllp_word_t body);
    crc16_t c;
    c = `DLLP_CRC_SEED;
    for (int i = 31; i >= 0; i--) begin
      if (c[15] ^ body[i]) begin
        c = (c << 1) ^ `DLLP_CRC_POLY;
      end else begin
        c = c << 1;
      end
    end
    return c;
  endfunction

  `include "dllp_rx_tasks.svh"

  initial begin
    rst      = 1'b1;
    link_up  = 1'b1;
    s_tdata  = '0;
    s_tvalid = 1'b0;
    s_tlast  = 1'b0;
    s_tuser  = '0;
    exp_hdr  = '{default: '0};
    exp_data = '{default: '0};
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_value("reset tready", 0, s_tready);
    check_value("reset seq_vld", 0, seq_vld);
    check_value("reset done", 0, {fc1_done, fc2_done});
    check_value("reset err_cnt", 0, crc_err_cnt);
    check_credits("reset");

    test_ack_nak();
    test_init_fc();
    test_update_fc();
    test_bad_crc();
    test_filter_and_link();
    test_back_to_back();

    if (report_q.size() != 0) begin
      errors++;
      $display("%0d sequence reports arrived that no DLLP asked for", report_q.size());
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+source
+incdir+bench
source/dllp_pkg.sv
source/dllp_skid_buffer.sv
source/dllp_crc16.sv
source/dllp_decoder.sv
source/fc_credit_store.sv
source/dllp_rx_top.sv
bench/dllp_rx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the DLLP receive testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module dllp_rx_tb \
  -f sim.f --Mdir obj_dir -o sim_dllp_rx
./obj_dir/sim_dllp_rx | tee sim.log

if grep -q "Test passed" sim.log; then
  echo "simulation result: pass"
else
  echo "simulation result: fail"
  exit 1
fi
